//--- csr_unit.f
hdl/csr_pkg.sv
hdl/csr_write_if.sv
hdl/csr_access_decode.sv
hdl/csr_exception_regs.sv
hdl/csr_timer.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
tb/csr_unit_checker.sv
tb/csr_unit_tb.sv

//--- hdl/csr_access_decode.sv
module csr_access_decode
    import csr_pkg::*;
(
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic                 csr_we,
    input  logic [XLEN-1:0]      csr_wmask,
    input  logic [XLEN-1:0]      csr_wvalue,
    csr_write_if.decoder         acc
);

    logic [NUM_CSR-1:0] sel;

    // Unknown numbers leave the select empty
    always_comb begin
        sel = '0;
        case (csr_num)
            CSR_ADDR_CRMD:   sel[CSR_IDX_CRMD] = 1'b1;
            CSR_ADDR_PRMD:   sel[CSR_IDX_PRMD] = 1'b1;
            CSR_ADDR_ECFG:   sel[CSR_IDX_ECFG] = 1'b1;
            CSR_ADDR_ESTAT:  sel[CSR_IDX_ESTAT] = 1'b1;
            CSR_ADDR_ERA:    sel[CSR_IDX_ERA] = 1'b1;
            CSR_ADDR_BADV:   sel[CSR_IDX_BADV] = 1'b1;
            CSR_ADDR_EENTRY: sel[CSR_IDX_EENTRY] = 1'b1;
            CSR_ADDR_SAVE0:  sel[CSR_IDX_SAVE0] = 1'b1;
            CSR_ADDR_SAVE1:  sel[CSR_IDX_SAVE0 + 1] = 1'b1;
            CSR_ADDR_SAVE2:  sel[CSR_IDX_SAVE0 + 2] = 1'b1;
            CSR_ADDR_SAVE3:  sel[CSR_IDX_SAVE0 + 3] = 1'b1;
            CSR_ADDR_TCFG:   sel[CSR_IDX_TCFG] = 1'b1;
            CSR_ADDR_TVAL:   sel[CSR_IDX_TVAL] = 1'b1;
            CSR_ADDR_TICLR:  sel[CSR_IDX_TICLR] = 1'b1;
            default:         sel = '0;
        endcase
    end

    assign acc.sel    = sel;
    assign acc.wr     = csr_we & (|sel);
    assign acc.wmask  = csr_wmask;
    assign acc.wvalue = csr_wvalue;

endmodule

//--- hdl/csr_exception_regs.sv
module csr_exception_regs
    import csr_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    csr_write_if.reg_block                   acc,
    input  logic                             wb_ex,
    input  logic                             ertn_flush,
    input  logic [XLEN-1:0]                  wb_pc,
    input  logic [XLEN-1:0]                  wb_vaddr,
    input  logic [5:0]                       wb_ecode,
    input  logic [8:0]                       wb_esubcode,
    input  logic                             timer_pending,
    output logic [NUM_EXC_CSR-1:0][XLEN-1:0] exc_words,
    output logic [XLEN-1:0]                  eentry,
    output logic [XLEN-1:0]                  era,
    output logic                             has_int
);

    logic [1:0]      crmd_plv;
    logic            crmd_ie;
    logic            crmd_da;
    logic            crmd_pg;
    logic [1:0]      prmd_pplv;
    logic            prmd_pie;
    logic [12:0]     ecfg_lie;
    logic [1:0]      estat_swi;
    logic [5:0]      estat_ecode;
    logic [8:0]      estat_esubcode;
    logic [XLEN-1:0] badv;
    logic [25:0]     eentry_va;
    logic [XLEN-1:0] save [4];
    logic [12:0]     estat_is;
    logic            addr_err;
    logic [NUM_EXC_CSR-1:0][XLEN-1:0] wr_words;

    // Per-register write data, merged against the current word
    always_comb begin
        for (int i = 0; i < NUM_EXC_CSR; i++)
            wr_words[i] = masked_merge(exc_words[i], acc.wmask, acc.wvalue);
    end

    function automatic logic wr_hit(input int unsigned idx);
        return acc.wr & acc.sel[idx];
    endfunction

    // CRMD: exception beats return beats software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= CRMD_RESET[CRMD_PLV +: 2];
            crmd_ie  <= CRMD_RESET[CRMD_IE];
            crmd_da  <= CRMD_RESET[CRMD_DA];
            crmd_pg  <= CRMD_RESET[CRMD_PG];
        end else begin
            if (wb_ex) begin
                crmd_plv <= 2'b0;
                crmd_ie  <= 1'b0;
            end else if (ertn_flush) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (wr_hit(CSR_IDX_CRMD)) begin
                crmd_plv <= wr_words[CSR_IDX_CRMD][CRMD_PLV +: 2];
                crmd_ie  <= wr_words[CSR_IDX_CRMD][CRMD_IE];
            end
            if (wr_hit(CSR_IDX_CRMD)) begin
                crmd_da <= wr_words[CSR_IDX_CRMD][CRMD_DA];
                crmd_pg <= wr_words[CSR_IDX_CRMD][CRMD_PG];
            end
        end
    end

    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= 13'b0;
            estat_swi      <= 2'b0;
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
            era            <= '0;
            badv           <= '0;
            eentry_va      <= 26'b0;
        end else begin
            if (wb_ex) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (wr_hit(CSR_IDX_PRMD)) begin
                prmd_pplv <= wr_words[CSR_IDX_PRMD][PRMD_PPLV +: 2];
                prmd_pie  <= wr_words[CSR_IDX_PRMD][PRMD_PIE];
            end
            if (wr_hit(CSR_IDX_ECFG))
                ecfg_lie <= wr_words[CSR_IDX_ECFG][12:0] & ECFG_LIE_MASK[12:0];
            // Only the two software interrupt bits are writable
            if (wr_hit(CSR_IDX_ESTAT))
                estat_swi <= wr_words[CSR_IDX_ESTAT][ESTAT_IS +: 2];
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
                era            <= wb_pc;
            end else if (wr_hit(CSR_IDX_ERA)) begin
                era <= wr_words[CSR_IDX_ERA];
            end
            // Fetch faults report the PC, others the data address
            if (wb_ex && addr_err)
                badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ?
                        wb_pc : wb_vaddr;
            else if (wr_hit(CSR_IDX_BADV))
                badv <= wr_words[CSR_IDX_BADV];
            if (wr_hit(CSR_IDX_EENTRY))
                eentry_va <= wr_words[CSR_IDX_EENTRY][EENTRY_VA +: 26];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset)
                save[i] <= '0;
            else if (wr_hit(CSR_IDX_SAVE0 + i))
                save[i] <= masked_merge(save[i], acc.wmask, acc.wvalue);
        end
    end

    // Hardware and IPI lines are not wired in this core
    always_comb begin
        estat_is = 13'b0;
        estat_is[1:0] = estat_swi;
        estat_is[IS_TIMER] = timer_pending;
    end

    always_comb begin
        exc_words = '0;
        exc_words[CSR_IDX_CRMD][CRMD_PLV +: 2] = crmd_plv;
        exc_words[CSR_IDX_CRMD][CRMD_IE] = crmd_ie;
        exc_words[CSR_IDX_CRMD][CRMD_DA] = crmd_da;
        exc_words[CSR_IDX_CRMD][CRMD_PG] = crmd_pg;
        exc_words[CSR_IDX_PRMD][PRMD_PPLV +: 2] = prmd_pplv;
        exc_words[CSR_IDX_PRMD][PRMD_PIE] = prmd_pie;
        exc_words[CSR_IDX_ECFG][12:0] = ecfg_lie;
        exc_words[CSR_IDX_ESTAT][ESTAT_IS +: 13] = estat_is;
        exc_words[CSR_IDX_ESTAT][ESTAT_ECODE +: 6] = estat_ecode;
        exc_words[CSR_IDX_ESTAT][ESTAT_ESUBCODE +: 9] = estat_esubcode;
        exc_words[CSR_IDX_ERA] = era;
        exc_words[CSR_IDX_BADV] = badv;
        exc_words[CSR_IDX_EENTRY][EENTRY_VA +: 26] = eentry_va;
        for (int i = 0; i < 4; i++)
            exc_words[CSR_IDX_SAVE0 + i] = save[i];
    end

    assign eentry  = exc_words[CSR_IDX_EENTRY];
    assign has_int = crmd_ie && ((estat_is & ecfg_lie) != 13'b0);

endmodule

//--- hdl/csr_pkg.sv
package csr_pkg;

    localparam int unsigned CSR_NUM_W = 14;
    localparam int unsigned XLEN      = 32;

    // Architectural register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_CRMD   = 14'h00;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_PRMD   = 14'h01;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_ECFG   = 14'h04;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_ESTAT  = 14'h05;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_ERA    = 14'h06;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_BADV   = 14'h07;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_EENTRY = 14'h0c;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_SAVE0  = 14'h30;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_SAVE1  = 14'h31;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_SAVE2  = 14'h32;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_SAVE3  = 14'h33;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_TCFG   = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_TVAL   = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_ADDR_TICLR  = 14'h44;

    // One-hot select positions, exception block first, timer block last
    localparam int unsigned CSR_IDX_CRMD   = 0;
    localparam int unsigned CSR_IDX_PRMD   = 1;
    localparam int unsigned CSR_IDX_ECFG   = 2;
    localparam int unsigned CSR_IDX_ESTAT  = 3;
    localparam int unsigned CSR_IDX_ERA    = 4;
    localparam int unsigned CSR_IDX_BADV   = 5;
    localparam int unsigned CSR_IDX_EENTRY = 6;
    localparam int unsigned CSR_IDX_SAVE0  = 7;
    localparam int unsigned CSR_IDX_TCFG   = 11;
    localparam int unsigned CSR_IDX_TVAL   = 12;
    localparam int unsigned CSR_IDX_TICLR  = 13;
    localparam int unsigned NUM_CSR        = 14;
    localparam int unsigned NUM_EXC_CSR    = 11;
    localparam int unsigned NUM_TMR_CSR    = NUM_CSR - NUM_EXC_CSR;

    // Field positions (LSB of multi-bit fields)
    localparam int unsigned CRMD_PLV       = 0;
    localparam int unsigned CRMD_IE        = 2;
    localparam int unsigned CRMD_DA        = 3;
    localparam int unsigned CRMD_PG        = 4;
    localparam int unsigned PRMD_PPLV      = 0;
    localparam int unsigned PRMD_PIE       = 2;
    localparam int unsigned ESTAT_IS       = 0;
    localparam int unsigned ESTAT_ECODE    = 16;
    localparam int unsigned ESTAT_ESUBCODE = 22;
    localparam int unsigned EENTRY_VA      = 6;
    localparam int unsigned TCFG_EN        = 0;
    localparam int unsigned TCFG_PERIODIC  = 1;
    localparam int unsigned TCFG_INITVAL   = 2;
    localparam int unsigned TICLR_CLR      = 0;
    localparam int unsigned IS_TIMER       = 11;

    localparam logic [XLEN-1:0] ECFG_LIE_MASK = 32'h0000_1bff;
    localparam logic [5:0]      ECODE_ADE     = 6'h08;
    localparam logic [5:0]      ECODE_ALE     = 6'h09;
    localparam logic [8:0]      ESUBCODE_ADEF = 9'h000;
    localparam logic [XLEN-1:0] TVAL_IDLE     = {XLEN{1'b1}};
    localparam logic [XLEN-1:0] CRMD_RESET    = 32'h0000_0008;

    function automatic logic [XLEN-1:0] masked_merge(
        input logic [XLEN-1:0] old_word,
        input logic [XLEN-1:0] mask,
        input logic [XLEN-1:0] new_word
    );
        return (mask & new_word) | (~mask & old_word);
    endfunction

endpackage

//--- hdl/csr_read_mux.sv
module csr_read_mux
    import csr_pkg::*;
(
    csr_write_if.reader                      acc,
    input  logic [NUM_EXC_CSR-1:0][XLEN-1:0] exc_words,
    input  logic [NUM_TMR_CSR-1:0][XLEN-1:0] timer_words,
    output logic [XLEN-1:0]                  csr_rvalue
);

    logic [NUM_CSR-1:0][XLEN-1:0] all_words;

    // Both blocks already sit in select order
    assign all_words = {timer_words, exc_words};

    // AND-OR select, empty select reads zero
    always_comb begin
        csr_rvalue = '0;
        for (int i = 0; i < NUM_CSR; i++)
            csr_rvalue = csr_rvalue | ({XLEN{acc.sel[i]}} & all_words[i]);
    end

endmodule

//--- hdl/csr_timer.sv
module csr_timer
    import csr_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    csr_write_if.reg_block                   acc,
    output logic                             timer_pending,
    output logic [NUM_TMR_CSR-1:0][XLEN-1:0] timer_words
);

    logic            tcfg_en;
    logic            tcfg_periodic;
    logic [29:0]     tcfg_initval;
    logic [XLEN-1:0] tval;
    logic [XLEN-1:0] tcfg_next;
    logic            wr_tcfg;
    logic            clr_pending;

    assign wr_tcfg   = acc.wr & acc.sel[CSR_IDX_TCFG];
    assign tcfg_next = masked_merge(timer_words[CSR_IDX_TCFG - NUM_EXC_CSR],
                                    acc.wmask, acc.wvalue);
    assign clr_pending = acc.wr & acc.sel[CSR_IDX_TICLR] &
                         acc.wmask[TICLR_CLR] & acc.wvalue[TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= 30'b0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_next[TCFG_EN];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[TCFG_INITVAL +: 30];
        end
    end

    // One-shot mode wraps past zero into the idle value and stops there
    always_ff @(posedge clk) begin
        if (reset)
            tval <= TVAL_IDLE;
        else if (wr_tcfg && tcfg_next[TCFG_EN])
            tval <= {tcfg_next[TCFG_INITVAL +: 30], 2'b00};
        else if (tcfg_en && tval != TVAL_IDLE) begin
            if (tval == '0 && tcfg_periodic)
                tval <= {tcfg_initval, 2'b00};
            else
                tval <= tval - 32'd1;
        end
    end

    // Setting wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset)
            timer_pending <= 1'b0;
        else if (tcfg_en && tval == '0)
            timer_pending <= 1'b1;
        else if (clr_pending)
            timer_pending <= 1'b0;
    end

    always_comb begin
        timer_words = '0;
        timer_words[CSR_IDX_TCFG - NUM_EXC_CSR][TCFG_EN] = tcfg_en;
        timer_words[CSR_IDX_TCFG - NUM_EXC_CSR][TCFG_PERIODIC] = tcfg_periodic;
        timer_words[CSR_IDX_TCFG - NUM_EXC_CSR][TCFG_INITVAL +: 30] = tcfg_initval;
        timer_words[CSR_IDX_TVAL - NUM_EXC_CSR] = tval;
    end

endmodule

//--- hdl/csr_unit.sv
module csr_unit
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic                 csr_we,
    input  logic [XLEN-1:0]      csr_wmask,
    input  logic [XLEN-1:0]      csr_wvalue,
    output logic [XLEN-1:0]      csr_rvalue,
    input  logic                 wb_ex,
    input  logic                 ertn_flush,
    input  logic [XLEN-1:0]      wb_pc,
    input  logic [XLEN-1:0]      wb_vaddr,
    input  logic [5:0]           wb_ecode,
    input  logic [8:0]           wb_esubcode,
    output logic [XLEN-1:0]      csr_eentry_data,
    output logic [XLEN-1:0]      csr_era_pc,
    output logic                 has_int
);

    logic [NUM_EXC_CSR-1:0][XLEN-1:0] exc_words;
    logic [NUM_TMR_CSR-1:0][XLEN-1:0] timer_words;
    logic                             timer_pending;

    csr_write_if acc ();

    csr_access_decode u_decode (
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .acc        (acc.decoder)
    );

    csr_exception_regs u_exc (
        .clk           (clk),
        .reset         (reset),
        .acc           (acc.reg_block),
        .wb_ex         (wb_ex),
        .ertn_flush    (ertn_flush),
        .wb_pc         (wb_pc),
        .wb_vaddr      (wb_vaddr),
        .wb_ecode      (wb_ecode),
        .wb_esubcode   (wb_esubcode),
        .timer_pending (timer_pending),
        .exc_words     (exc_words),
        .eentry        (csr_eentry_data),
        .era           (csr_era_pc),
        .has_int       (has_int)
    );

    csr_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .acc           (acc.reg_block),
        .timer_pending (timer_pending),
        .timer_words   (timer_words)
    );

    csr_read_mux u_rmux (
        .acc         (acc.reader),
        .exc_words   (exc_words),
        .timer_words (timer_words),
        .csr_rvalue  (csr_rvalue)
    );

endmodule

//--- hdl/csr_write_if.sv
interface csr_write_if
    import csr_pkg::*;
();

    logic [NUM_CSR-1:0] sel;
    logic               wr;
    logic [XLEN-1:0]    wmask;
    logic [XLEN-1:0]    wvalue;

    modport decoder (output sel, output wr, output wmask, output wvalue);

    modport reg_block (input sel, input wr, input wmask, input wvalue);

    // Read side only needs the select
    modport reader (input sel);

endinterface

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module csr_unit_tb -f csr_unit.f -o csr_unit_sim \
    || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/csr_unit_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Test completed successfully" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/csr_unit_checker.sv
module csr_unit_checker
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 check,
    input  logic                 done,
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic [XLEN-1:0]      csr_rvalue,
    input  logic [XLEN-1:0]      csr_eentry_data,
    input  logic [XLEN-1:0]      csr_era_pc,
    input  logic                 has_int,
    input  logic [XLEN-1:0]      exp_word,
    input  logic                 exp_int,
    output int                   error_total
);
    timeunit 1ns;
    timeprecision 1ps;

    int checks = 0;
    int word_errors = 0;
    int int_errors = 0;
    int port_errors = 0;

    assign error_total = word_errors + int_errors + port_errors;

    // Inputs change just after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (check) begin
            checks++;
            if (csr_rvalue !== exp_word) begin
                word_errors++;
                $display("error at %0d ns: CSR 0x%03h read 0x%08h, expected 0x%08h",
                         $time, csr_num, csr_rvalue, exp_word);
            end
            if (has_int !== exp_int) begin
                int_errors++;
                $display("error at %0d ns: CSR 0x%03h step has_int %0b, expected %0b",
                         $time, csr_num, has_int, exp_int);
            end
            // Dedicated outputs must match the register they mirror
            if (csr_num == CSR_ADDR_EENTRY && csr_eentry_data !== exp_word) begin
                port_errors++;
                $display("error at %0d ns: csr_eentry_data 0x%08h, expected 0x%08h",
                         $time, csr_eentry_data, exp_word);
            end
            if (csr_num == CSR_ADDR_ERA && csr_era_pc !== exp_word) begin
                port_errors++;
                $display("error at %0d ns: csr_era_pc 0x%08h, expected 0x%08h",
                         $time, csr_era_pc, exp_word);
            end
        end
    end

    always @(posedge done) begin
        $display("%0d checks: %0d read word errors, %0d has_int errors, %0d port errors",
                 checks, word_errors, int_errors, port_errors);
    end

endmodule

//--- tb/csr_unit_tb.sv
module csr_unit_tb
    import csr_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_EXC, OP_RET, OP_WAIT} op_t;

    typedef struct packed {
        op_t                  op;
        logic [CSR_NUM_W-1:0] num;
        logic [XLEN-1:0]      mask;
        logic [XLEN-1:0]      value;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      addr;
        logic [5:0]           ecode;
        logic [8:0]           subcode;
        int                   cycles;
        logic [XLEN-1:0]      exp_word;
        logic                 exp_int;
    } step_t;

    logic                 clk;
    logic                 reset;
    logic [CSR_NUM_W-1:0] csr_num;
    logic                 csr_we;
    logic [XLEN-1:0]      csr_wmask;
    logic [XLEN-1:0]      csr_wvalue;
    logic [XLEN-1:0]      csr_rvalue;
    logic                 wb_ex;
    logic                 ertn_flush;
    logic [XLEN-1:0]      wb_pc;
    logic [XLEN-1:0]      wb_vaddr;
    logic [5:0]           wb_ecode;
    logic [8:0]           wb_esubcode;
    logic [XLEN-1:0]      csr_eentry_data;
    logic [XLEN-1:0]      csr_era_pc;
    logic                 has_int;
    logic                 check;
    logic                 done;
    logic [XLEN-1:0]      exp_word;
    logic                 exp_int;
    int                   error_total;
    int                   limit_ns = 0;
    step_t                steps[$];

    csr_unit dut (.*);

    csr_unit_checker chk (
        .clk             (clk),
        .check           (check),
        .done            (done),
        .csr_num         (csr_num),
        .csr_rvalue      (csr_rvalue),
        .csr_eentry_data (csr_eentry_data),
        .csr_era_pc      (csr_era_pc),
        .has_int         (has_int),
        .exp_word        (exp_word),
        .exp_int         (exp_int),
        .error_total     (error_total)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_step(input op_t op, input logic [CSR_NUM_W-1:0] num,
                            input logic [XLEN-1:0] mask, input logic [XLEN-1:0] value,
                            input logic [XLEN-1:0] pc, input logic [XLEN-1:0] addr,
                            input logic [5:0] ecode, input logic [8:0] subcode,
                            input int cycles, input logic [XLEN-1:0] word,
                            input logic int_req);
        step_t s;
        s.op       = op;
        s.num      = num;
        s.mask     = mask;
        s.value    = value;
        s.pc       = pc;
        s.addr     = addr;
        s.ecode    = ecode;
        s.subcode  = subcode;
        s.cycles   = cycles;
        s.exp_word = word;
        s.exp_int  = int_req;
        steps.push_back(s);
    endtask

    task automatic add_write(input logic [CSR_NUM_W-1:0] num, input logic [XLEN-1:0] mask,
                             input logic [XLEN-1:0] value);
        add_step(OP_WRITE, num, mask, value, '0, '0, '0, '0, 1, '0, 1'b0);
    endtask

    task automatic add_read(input logic [CSR_NUM_W-1:0] num, input logic [XLEN-1:0] word,
                            input logic int_req);
        add_step(OP_READ, num, '0, '0, '0, '0, '0, '0, 1, word, int_req);
    endtask

    task automatic add_exception(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] addr,
                                 input logic [5:0] ecode, input logic [8:0] subcode);
        add_step(OP_EXC, '0, '0, '0, pc, addr, ecode, subcode, 1, '0, 1'b0);
    endtask

    task automatic add_wait(input int cycles);
        add_step(OP_WAIT, '0, '0, '0, '0, '0, '0, '0, cycles, '0, 1'b0);
    endtask

    task automatic build_table();
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] save_model [4];
        add_read(CSR_ADDR_CRMD, 32'h0000_0008, 1'b0);
        add_read(CSR_ADDR_TVAL, 32'hffff_ffff, 1'b0);
        add_read(CSR_ADDR_ESTAT, 32'h0, 1'b0);
        add_read(CSR_ADDR_ECFG, 32'h0, 1'b0);
        add_read(CSR_ADDR_TCFG, 32'h0, 1'b0);
        add_read(14'h123, 32'h0, 1'b0);
        // SAVE registers, two masked writes each on top of the reset value
        for (int i = 0; i < 4; i++) begin
            save_model[i] = '0;
            add_read(CSR_ADDR_SAVE0 + 14'(i), 32'h0, 1'b0);
            for (int k = 0; k < 2; k++) begin
                mask = $urandom();
                value = $urandom();
                save_model[i] = (mask & value) | (~mask & save_model[i]);
                add_write(CSR_ADDR_SAVE0 + 14'(i), mask, value);
                add_read(CSR_ADDR_SAVE0 + 14'(i), save_model[i], 1'b0);
            end
        end
        add_write(CSR_ADDR_ECFG, 32'hffff_ffff, 32'hffff_ffff);
        add_read(CSR_ADDR_ECFG, 32'h0000_1bff, 1'b0);
        add_write(CSR_ADDR_ECFG, 32'hffff_ffff, 32'h0);
        add_read(CSR_ADDR_ECFG, 32'h0, 1'b0);
        add_write(CSR_ADDR_TICLR, 32'hffff_ffff, 32'hffff_ffff);
        add_read(CSR_ADDR_TICLR, 32'h0, 1'b0);
        // Exception entry and return
        add_write(CSR_ADDR_EENTRY, 32'hffff_ffff, 32'h1c00_807f);
        add_read(CSR_ADDR_EENTRY, 32'h1c00_8040, 1'b0);
        add_write(CSR_ADDR_CRMD, 32'h0000_0007, 32'h0000_0007);
        add_read(CSR_ADDR_CRMD, 32'h0000_000f, 1'b0);
        add_exception(32'h1c00_1000, 32'hdead_beef, 6'h08, 9'h000);
        add_read(CSR_ADDR_CRMD, 32'h0000_0008, 1'b0);
        add_read(CSR_ADDR_PRMD, 32'h0000_0007, 1'b0);
        add_read(CSR_ADDR_ERA, 32'h1c00_1000, 1'b0);
        add_read(CSR_ADDR_BADV, 32'h1c00_1000, 1'b0);
        add_read(CSR_ADDR_ESTAT, 32'h0008_0000, 1'b0);
        add_step(OP_RET, '0, '0, '0, '0, '0, '0, '0, 1, '0, 1'b0);
        add_read(CSR_ADDR_CRMD, 32'h0000_000f, 1'b0);
        add_exception(32'h1c00_2004, 32'h0000_1235, 6'h09, 9'h000);
        add_read(CSR_ADDR_BADV, 32'h0000_1235, 1'b0);
        add_read(CSR_ADDR_ERA, 32'h1c00_2004, 1'b0);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0000, 1'b0);
        add_step(OP_RET, '0, '0, '0, '0, '0, '0, '0, 1, '0, 1'b0);
        add_read(CSR_ADDR_CRMD, 32'h0000_000f, 1'b0);
        // Software interrupt, then drop each of its three conditions
        add_write(CSR_ADDR_ECFG, 32'hffff_ffff, 32'h0000_0001);
        add_read(CSR_ADDR_ECFG, 32'h0000_0001, 1'b0);
        add_write(CSR_ADDR_ESTAT, 32'h0000_0003, 32'h0000_0001);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0001, 1'b1);
        add_write(CSR_ADDR_ESTAT, 32'h0000_0001, 32'h0);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0000, 1'b0);
        add_write(CSR_ADDR_ESTAT, 32'h0000_0001, 32'h0000_0001);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0001, 1'b1);
        add_write(CSR_ADDR_ECFG, 32'h0000_0001, 32'h0);
        add_read(CSR_ADDR_ECFG, 32'h0, 1'b0);
        add_write(CSR_ADDR_ECFG, 32'h0000_0001, 32'h0000_0001);
        add_read(CSR_ADDR_ECFG, 32'h0000_0001, 1'b1);
        add_write(CSR_ADDR_CRMD, 32'h0000_0004, 32'h0);
        add_read(CSR_ADDR_CRMD, 32'h0000_000b, 1'b0);
        add_write(CSR_ADDR_ESTAT, 32'h0000_0003, 32'h0);
        add_write(CSR_ADDR_CRMD, 32'h0000_0004, 32'h0000_0004);
        add_read(CSR_ADDR_CRMD, 32'h0000_000f, 1'b0);
        // One-shot timer, INITVAL 5 gives a 20 count
        add_write(CSR_ADDR_ECFG, 32'hffff_ffff, 32'h0000_0800);
        add_read(CSR_ADDR_ECFG, 32'h0000_0800, 1'b0);
        add_write(CSR_ADDR_TCFG, 32'hffff_ffff, 32'h0000_0015);
        add_read(CSR_ADDR_TCFG, 32'h0000_0015, 1'b0);
        add_wait(40);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0800, 1'b1);
        add_read(CSR_ADDR_TVAL, 32'hffff_ffff, 1'b1);
        add_write(CSR_ADDR_TICLR, 32'h0000_0001, 32'h0000_0001);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0000, 1'b0);
        // Periodic timer reloads every 21 cycles
        add_write(CSR_ADDR_TCFG, 32'hffff_ffff, 32'h0000_0017);
        add_read(CSR_ADDR_TCFG, 32'h0000_0017, 1'b0);
        add_wait(40);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0800, 1'b1);
        add_write(CSR_ADDR_TICLR, 32'h0000_0001, 32'h0000_0001);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0000, 1'b0);
        add_wait(40);
        add_read(CSR_ADDR_ESTAT, 32'h0009_0800, 1'b1);
        add_read(CSR_ADDR_TVAL, 32'h0000_0013, 1'b1);
        add_wait(2);
    endtask

    task automatic run_step(input step_t s);
        @(posedge clk);
        #1;
        csr_num     = s.num;
        csr_wmask   = s.mask;
        csr_wvalue  = s.value;
        wb_pc       = s.pc;
        wb_vaddr    = s.addr;
        wb_ecode    = s.ecode;
        wb_esubcode = s.subcode;
        exp_word    = s.exp_word;
        exp_int     = s.exp_int;
        csr_we      = (s.op == OP_WRITE);
        check       = (s.op == OP_READ);
        wb_ex       = (s.op == OP_EXC);
        ertn_flush  = (s.op == OP_RET);
        if (s.op == OP_WAIT)
            repeat (s.cycles - 1) @(posedge clk);
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout: the step table was still running after %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        int longest;
        void'($urandom(12137));
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        check       = 1'b0;
        done        = 1'b0;
        exp_word    = '0;
        exp_int     = 1'b0;
        build_table();
        longest = 1;
        foreach (steps[i])
            if (steps[i].cycles > longest)
                longest = steps[i].cycles;
        limit_ns = steps.size() * longest * 10 * 2;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < steps.size(); i++)
            run_step(steps[i]);
        done = 1'b1;
        #1;
        if (error_total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
